// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_patch_search
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
hdl/patch_pkg.sv
hdl/scan_if.sv
hdl/pixel_ram.sv
hdl/window_sequencer.sv
hdl/row_buffer.sv
hdl/sad_matcher.sv
hdl/patch_search_top.sv
tests/tb_patch_search.sv

// ==== hdl/patch_pkg.sv ====
package patch_pkg;

	typedef logic [7:0]  pixel_t;   // one grayscale pixel.
	typedef logic [31:0] word_t;    // four pixels, column 4k+i in byte i.
	typedef logic [6:0]  coord_t;   // row or column index up to 127.
	typedef logic [15:0] sad_t;     // sad score for windows up to 16x16.

	localparam int IMG_W_DEF    = 32;   // default image width in pixels.
	localparam int IMG_H_DEF    = 32;   // default image height in pixels.
	localparam int WIN_DEF      = 8;    // default square window size.
	localparam int PIX_PER_WORD = 4;    // pixels packed in one memory word.

	// scan control flow of the window sequencer
	typedef enum logic [2:0] {
		IDLE,       // waiting for en.
		FILL,       // reading the first WIN rows.
		SLIDE,      // one window per cycle.
		NEXT_ROW,   // shift up and read one more row.
		FINISH      // waiting for the last compare.
	} seq_state_t;

endpackage

// ==== hdl/patch_search_top.sv ====
`timescale 1ns/100ps

module patch_search_top import patch_pkg::*; #(
	parameter  int IMG_W   = IMG_W_DEF,
	parameter  int IMG_H   = IMG_H_DEF,
	parameter  int WIN     = WIN_DEF,
	localparam int IMG_AW  = $clog2((IMG_W / PIX_PER_WORD) * IMG_H),
	localparam int TMPL_AW = $clog2(WIN * WIN)
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               img_we,
	input  logic [IMG_AW-1:0]  img_addr,
	input  word_t              img_data,
	input  logic               tmpl_we,
	input  logic [TMPL_AW-1:0] tmpl_addr,
	input  pixel_t             tmpl_data,
	input  logic               en,
	output logic               ack,
	output logic               busy,
	output logic               done,
	output coord_t             best_row,
	output coord_t             best_col,
	output sad_t               best_sad
);

	logic [IMG_AW-1:0]         rd_addr;
	word_t                     rd_data;
	coord_t                    top_row;      // window top row, aligned with win_ready.
	pixel_t [WIN-1:0][WIN-1:0] window_data;

	scan_if scan ();

	pixel_ram #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_ram (
		.clk(clk), .we(img_we), .wr_addr(img_addr), .wr_data(img_data),
		.rd_addr(rd_addr), .rd_data(rd_data)
	);

	window_sequencer #(.IMG_W(IMG_W), .IMG_H(IMG_H), .WIN(WIN)) u_seq (
		.clk(clk), .rst_n(rst_n), .en(en), .done(done), .ack(ack), .busy(busy),
		.rd_addr(rd_addr), .top_row(top_row), .scan(scan.seq)
	);

	row_buffer #(.IMG_W(IMG_W), .WIN(WIN)) u_buf (
		.clk(clk), .rst_n(rst_n), .rd_data(rd_data), .scan(scan.buffer),
		.window_data(window_data)
	);

	sad_matcher #(.WIN(WIN)) u_match (
		.clk(clk), .rst_n(rst_n), .tmpl_we(tmpl_we), .tmpl_addr(tmpl_addr),
		.tmpl_data(tmpl_data), .window_data(window_data), .scan(scan.match),
		.top_row(top_row), .start(ack), .done(done), .best_row(best_row),
		.best_col(best_col), .best_sad(best_sad)
	);

endmodule

// ==== hdl/pixel_ram.sv ====
`timescale 1ns/100ps

module pixel_ram import patch_pkg::*; #(
	parameter  int IMG_W = IMG_W_DEF,
	parameter  int IMG_H = IMG_H_DEF,
	localparam int DEPTH = (IMG_W / PIX_PER_WORD) * IMG_H,
	localparam int AW    = $clog2(DEPTH)
) (
	input  logic          clk,
	input  logic          we,
	input  logic [AW-1:0] wr_addr,
	input  word_t         wr_data,
	input  logic [AW-1:0] rd_addr,
	output word_t         rd_data
);

	word_t mem [DEPTH];  // image stored row by row.

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_addr] <= wr_data;  // host write port.
		end
	end

	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];  // registered read, one cycle latency.
	end

	// host writes and scan reads stay inside the image
	a_wr_in_range: assert property (
		@(posedge clk) we |-> (int'(wr_addr) < DEPTH)
	) else $error("pixel_ram write address out of range");

	a_rd_in_range: assert property (
		@(posedge clk) int'(rd_addr) < DEPTH
	) else $error("pixel_ram read address out of range");

endmodule

// ==== hdl/row_buffer.sv ====
`timescale 1ns/100ps

module row_buffer import patch_pkg::*; #(
	parameter int IMG_W = IMG_W_DEF,
	parameter int WIN   = WIN_DEF
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  word_t                        rd_data,
	scan_if.buffer                       scan,
	output pixel_t [WIN-1:0][WIN-1:0]    window_data
);

	pixel_t [WIN-1:0][IMG_W-1:0] rows;  // WIN full image rows, top row first.

	always_ff @(posedge clk, negedge rst_n) begin
		int base;
		if (!rst_n) begin
			rows <= '0;
		end else begin
			base = int'(scan.buf_col) * PIX_PER_WORD;  // first pixel of the word.
			if (scan.new_row) begin
				for (int r = 0; r < WIN - 1; r++) begin
					rows[r] <= rows[r+1];  // drop the old top row.
				end
			end
			if (scan.load) begin
				for (int i = 0; i < PIX_PER_WORD; i++) begin
					rows[scan.buf_row][base+i] <= rd_data[8*i +: 8];  // byte i is column 4k+i.
				end
			end
		end
	end

	always_comb begin
		for (int r = 0; r < WIN; r++) begin
			for (int c = 0; c < WIN; c++) begin
				window_data[r][c] = rows[r][int'(scan.win_offset) + c];  // slice at offset.
			end
		end
	end

endmodule

// ==== hdl/sad_matcher.sv ====
`timescale 1ns/100ps

module sad_matcher import patch_pkg::*; #(
	parameter  int WIN = WIN_DEF,
	localparam int TAW = $clog2(WIN * WIN)
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      tmpl_we,
	input  logic [TAW-1:0]            tmpl_addr,
	input  pixel_t                    tmpl_data,
	input  pixel_t [WIN-1:0][WIN-1:0] window_data,
	scan_if.match                     scan,
	input  coord_t                    top_row,
	input  logic                      start,
	output logic                      done,
	output coord_t                    best_row,
	output coord_t                    best_col,
	output sad_t                      best_sad
);

	pixel_t tmpl [WIN*WIN];  // template, row * WIN + col.
	sad_t   row_sad [WIN];   // per-row sums of the current window.
	sad_t   s1_sum [WIN];
	logic   s1_valid;
	logic   s1_last;
	coord_t s1_row;
	coord_t s1_col;
	sad_t   total;

	function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	always_ff @(posedge clk) begin
		if (tmpl_we) begin
			tmpl[tmpl_addr] <= tmpl_data;
		end
	end

	always_comb begin
		for (int r = 0; r < WIN; r++) begin
			row_sad[r] = '0;
			for (int c = 0; c < WIN; c++) begin
				row_sad[r] = row_sad[r] + sad_t'(abs_diff(window_data[r][c], tmpl[r*WIN+c]));
			end
		end
	end

	always_comb begin
		total = '0;
		for (int r = 0; r < WIN; r++) begin
			total = total + s1_sum[r];  // stage two adder tree.
		end
	end

	always_ff @(posedge clk) begin
		if (scan.win_ready) begin
			s1_sum <= row_sad;  // stage one payload.
			s1_row <= top_row;
			s1_col <= scan.win_offset;
		end
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s1_last  <= 1'b0;
			done     <= 1'b0;
			best_sad <= '1;
			best_row <= '0;
			best_col <= '0;
		end else begin
			s1_valid <= scan.win_ready;
			s1_last  <= scan.win_ready && scan.last_win;
			done     <= s1_valid && s1_last;  // two cycles after the last window.
			if (start) begin
				best_sad <= '1;  // new scan.
				best_row <= '0;
				best_col <= '0;
			end else if (s1_valid && (total < best_sad)) begin
				best_sad <= total;  // strict less keeps the earliest tie.
				best_row <= s1_row;
				best_col <= s1_col;
			end
		end
	end

endmodule

// ==== hdl/scan_if.sv ====
`timescale 1ns/100ps

interface scan_if import patch_pkg::*; ();

	logic   load;        // row buffer write strobe.
	coord_t buf_row;     // buffer row for the arriving word.
	coord_t buf_col;     // word column for the arriving word.
	logic   new_row;     // shift buffer rows up before the write.
	logic   win_ready;   // window at win_offset is valid.
	coord_t win_offset;  // left column of the window.
	logic   last_win;    // final window of the scan.

	modport seq (
		output load, buf_row, buf_col, new_row,
		output win_ready, win_offset, last_win
	);

	modport buffer (
		input load, buf_row, buf_col, new_row, win_offset
	);

	modport match (
		input win_ready, win_offset, last_win
	);

endinterface

// ==== hdl/window_sequencer.sv ====
`timescale 1ns/100ps

module window_sequencer import patch_pkg::*; #(
	parameter  int IMG_W = IMG_W_DEF,
	parameter  int IMG_H = IMG_H_DEF,
	parameter  int WIN   = WIN_DEF,
	localparam int WPR   = IMG_W / PIX_PER_WORD,
	localparam int AW    = $clog2(WPR * IMG_H)
) (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          en,
	input  logic          done,
	output logic          ack,
	output logic          busy,
	output logic [AW-1:0] rd_addr,
	output coord_t        top_row,
	scan_if.seq           scan
);

	localparam coord_t LAST_OFF  = coord_t'(IMG_W - WIN);  // rightmost window column.
	localparam coord_t LAST_TOP  = coord_t'(IMG_H - WIN);  // lowest window top row.
	localparam coord_t LAST_WCOL = coord_t'(WPR - 1);      // last word in a row.
	localparam coord_t LAST_BROW = coord_t'(WIN - 1);      // bottom buffer row.

	seq_state_t state, state_n;
	coord_t     rd_row, rd_row_n;  // image row being read.
	coord_t     rd_col, rd_col_n;  // word column being read.
	coord_t     offset, offset_n;  // window left column.
	coord_t     top, top_n;        // image row at the window top.
	logic       load_c;
	logic       new_row_c;
	logic       win_ready_c;
	logic       last_c;
	coord_t     buf_row_c;

	assign rd_addr = AW'(int'(rd_row) * WPR + int'(rd_col));  // row * words per row + col.
	assign busy    = (state != IDLE) && !done;                // drops together with done.

	always_comb begin
		state_n     = state;
		rd_row_n    = rd_row;
		rd_col_n    = rd_col;
		offset_n    = offset;
		top_n       = top;
		ack         = 1'b0;
		load_c      = 1'b0;
		new_row_c   = 1'b0;
		win_ready_c = 1'b0;
		last_c      = 1'b0;
		buf_row_c   = rd_row;
		case (state)
			IDLE: begin
				if (en) begin
					ack      = 1'b1;  // same cycle as en.
					rd_row_n = '0;
					rd_col_n = '0;
					offset_n = '0;
					top_n    = '0;
					state_n  = FILL;
				end
			end
			FILL: begin
				load_c    = 1'b1;
				buf_row_c = rd_row;  // buffer row equals image row here.
				if (rd_col == LAST_WCOL) begin
					rd_col_n = '0;
					if (rd_row == LAST_BROW) begin
						state_n = SLIDE;  // first WIN rows requested.
					end else begin
						rd_row_n = rd_row + 1'b1;
					end
				end else begin
					rd_col_n = rd_col + 1'b1;
				end
			end
			SLIDE: begin
				win_ready_c = 1'b1;
				last_c      = (offset == LAST_OFF) && (top == LAST_TOP);
				if (offset == LAST_OFF) begin
					offset_n = '0;
					if (top == LAST_TOP) begin
						state_n = FINISH;  // last window issued.
					end else begin
						rd_row_n = coord_t'(top + WIN);  // row entering at the bottom.
						rd_col_n = '0;
						top_n    = top + 1'b1;
						state_n  = NEXT_ROW;
					end
				end else begin
					offset_n = offset + 1'b1;
				end
			end
			NEXT_ROW: begin
				load_c    = 1'b1;
				new_row_c = (rd_col == '0);  // shift only before the first word.
				buf_row_c = LAST_BROW;
				if (rd_col == LAST_WCOL) begin
					state_n = SLIDE;
				end else begin
					rd_col_n = rd_col + 1'b1;
				end
			end
			FINISH: begin
				if (done) begin
					state_n = IDLE;  // matcher finished the last compare.
				end
			end
			default: state_n = IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state           <= IDLE;
			rd_row          <= '0;
			rd_col          <= '0;
			offset          <= '0;
			top             <= '0;
			scan.load       <= 1'b0;
			scan.new_row    <= 1'b0;
			scan.buf_row    <= '0;
			scan.buf_col    <= '0;
			scan.win_ready  <= 1'b0;
			scan.win_offset <= '0;
			scan.last_win   <= 1'b0;
			top_row         <= '0;
		end else begin
			state           <= state_n;
			rd_row          <= rd_row_n;
			rd_col          <= rd_col_n;
			offset          <= offset_n;
			top             <= top_n;
			scan.load       <= load_c;       // lines up with rd_data.
			scan.new_row    <= new_row_c;
			scan.buf_row    <= buf_row_c;
			scan.buf_col    <= rd_col;
			scan.win_ready  <= win_ready_c;  // delayed so the last word is in.
			scan.win_offset <= offset;
			scan.last_win   <= last_c;
			top_row         <= top;
		end
	end

	// buffer is never written while a window is being scored
	a_no_load_on_window: assert property (
		@(posedge clk) disable iff (!rst_n) !(scan.load && scan.win_ready)
	) else $error("load and win_ready high together");

	a_offset_in_range: assert property (
		@(posedge clk) disable iff (!rst_n) scan.win_ready |-> (scan.win_offset <= LAST_OFF)
	) else $error("win_offset beyond last window column");

endmodule

// ==== tests/tb_patch_search.sv ====
`timescale 1ns/100ps

module tb_patch_search import patch_pkg::*; ();

	localparam int IMG_W   = 32;
	localparam int IMG_H   = 32;
	localparam int WIN     = 8;
	localparam int WPR     = IMG_W / PIX_PER_WORD;         // words per image row.
	localparam int IMG_AW  = $clog2(WPR * IMG_H);
	localparam int TMPL_AW = $clog2(WIN * WIN);
	localparam int TIMEOUT = 5000;                         // cycles allowed per scan.

	logic               clk;
	logic               rst_n;
	logic               img_we;
	logic [IMG_AW-1:0]  img_addr;
	word_t              img_data;
	logic               tmpl_we;
	logic [TMPL_AW-1:0] tmpl_addr;
	pixel_t             tmpl_data;
	logic               en;
	logic               ack;
	logic               busy;
	logic               done;
	coord_t             best_row;
	coord_t             best_col;
	sad_t               best_sad;

	pixel_t      img [IMG_H][IMG_W];  // model copy of the image.
	pixel_t      tmpl [WIN][WIN];     // model copy of the template.
	logic [31:0] rng;
	coord_t      exp_row;             // reference result kept for the rescan.
	coord_t      exp_col;
	sad_t        exp_sad;

	patch_search_top #(.IMG_W(IMG_W), .IMG_H(IMG_H), .WIN(WIN)) dut (
		.clk(clk), .rst_n(rst_n), .img_we(img_we), .img_addr(img_addr),
		.img_data(img_data), .tmpl_we(tmpl_we), .tmpl_addr(tmpl_addr),
		.tmpl_data(tmpl_data), .en(en), .ack(ack), .busy(busy), .done(done),
		.best_row(best_row), .best_col(best_col), .best_sad(best_sad)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // 20 ns period.
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic pixel_t next_pixel();
		rng = xorshift(rng);
		return rng[7:0];  // low byte as pixel.
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Errors found");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_result(input coord_t row, input coord_t col, input sad_t sad);
		check_value("best_row", best_row, row);
		check_value("best_col", best_col, col);
		check_value("best_sad", best_sad, sad);
	endtask

	task automatic write_image();
		for (int r = 0; r < IMG_H; r++) begin
			for (int k = 0; k < WPR; k++) begin
				@(negedge clk);
				img_we   = 1'b1;
				img_addr = IMG_AW'(r * WPR + k);  // row * words per row + word.
				img_data = {img[r][4*k+3], img[r][4*k+2], img[r][4*k+1], img[r][4*k]};
			end
		end
		@(negedge clk);
		img_we = 1'b0;
	endtask

	task automatic write_template();
		for (int r = 0; r < WIN; r++) begin
			for (int c = 0; c < WIN; c++) begin
				@(negedge clk);
				tmpl_we   = 1'b1;
				tmpl_addr = TMPL_AW'(r * WIN + c);
				tmpl_data = tmpl[r][c];
			end
		end
		@(negedge clk);
		tmpl_we = 1'b0;
	endtask

	task automatic fill_random_image();
		for (int r = 0; r < IMG_H; r++) begin
			for (int c = 0; c < IMG_W; c++) begin
				img[r][c] = next_pixel();
			end
		end
	endtask

	// exhaustive sad over all positions, raster order, strict less.
	task automatic reference_search(output coord_t row, output coord_t col, output sad_t sad);
		int s;
		int d;
		sad = '1;
		row = '0;
		col = '0;
		for (int tr = 0; tr <= IMG_H - WIN; tr++) begin
			for (int tc = 0; tc <= IMG_W - WIN; tc++) begin
				s = 0;
				for (int r = 0; r < WIN; r++) begin
					for (int c = 0; c < WIN; c++) begin
						d = int'(img[tr+r][tc+c]) - int'(tmpl[r][c]);
						s += (d < 0) ? -d : d;
					end
				end
				if (s < int'(sad)) begin
					sad = sad_t'(s);  // earliest position wins ties.
					row = coord_t'(tr);
					col = coord_t'(tc);
				end
			end
		end
	endtask

	// one en pulse, optional stray en during the scan, then wait for done.
	task automatic run_scan(input bit poke_en);
		int cycles;
		int acks;
		int dones;
		cycles = 0;
		acks   = 0;
		dones  = 0;
		@(negedge clk);
		en = 1'b1;
		#1;
		if (ack) acks++;  // ack follows en in the same cycle.
		@(negedge clk);
		en = 1'b0;
		#1;
		check_value("busy", busy, 1);
		while (dones == 0) begin
			if (cycles == TIMEOUT) begin
				$display("Timed out waiting for done after %0d cycles", cycles);
				$display("Errors found");
				$fatal(1, "scan timeout");
			end
			@(negedge clk);
			en = poke_en && (cycles == 40 || cycles == 400);  // ignored while busy.
			#1;
			if (ack) acks++;
			if (done) dones++;
			cycles++;
		end
		en = 1'b0;
		repeat (4) begin
			@(negedge clk);
			#1;
			if (ack) acks++;
			if (done) dones++;  // must stay a single pulse.
		end
		check_value("ack count", acks, 1);
		check_value("done count", dones, 1);
		check_value("busy", busy, 0);
	endtask

	task automatic test_reset_state();
		check_value("ack", ack, 0);
		check_value("busy", busy, 0);
		check_value("done", done, 0);
		check_result('0, '0, '1);  // reset values.
	endtask

	task automatic test_exact_match();
		fill_random_image();
		for (int r = 0; r < WIN; r++) begin
			for (int c = 0; c < WIN; c++) begin
				tmpl[r][c] = img[13+r][9+c];  // copied patch.
			end
		end
		write_image();
		write_template();
		run_scan(1'b0);
		check_result(7'd13, 7'd9, 16'd0);
	endtask

	task automatic test_flat_tie();
		for (int r = 0; r < IMG_H; r++) begin
			for (int c = 0; c < IMG_W; c++) begin
				img[r][c] = 8'd0;
			end
		end
		for (int r = 0; r < WIN; r++) begin
			for (int c = 0; c < WIN; c++) begin
				tmpl[r][c] = 8'd5;
			end
		end
		write_image();
		write_template();
		run_scan(1'b0);
		check_result(7'd0, 7'd0, sad_t'(5 * WIN * WIN));  // every window ties.
	endtask

	task automatic test_random_match();
		fill_random_image();
		for (int r = 0; r < WIN; r++) begin
			for (int c = 0; c < WIN; c++) begin
				tmpl[r][c] = next_pixel();
			end
		end
		write_image();
		write_template();
		reference_search(exp_row, exp_col, exp_sad);
		run_scan(1'b0);
		check_result(exp_row, exp_col, exp_sad);
	endtask

	task automatic test_repeat_scan();
		run_scan(1'b1);  // same data, stray en pulses.
		check_result(exp_row, exp_col, exp_sad);
	endtask

	initial begin
		rng       = 32'd60;
		rst_n     = 1'b0;
		img_we    = 1'b0;
		img_addr  = '0;
		img_data  = '0;
		tmpl_we   = 1'b0;
		tmpl_addr = '0;
		tmpl_data = '0;
		en        = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset_state();
		test_exact_match();
		test_flat_tie();
		test_random_match();
		test_repeat_scan();
		$display("No errors");
		$finish;
	end

endmodule
